/* rtl/bpc_pkg.sv */
/*
 * widths, vector types and bus structs shared by the
 * bit-plane compression engine
 */
package bpc_pkg;

    // --------------------
    // widths
    localparam int WORD_W          = 16;
    localparam int BEAT_W          = 64;
    localparam int BEATS_PER_BLOCK = 16;
    localparam int PLANES          = 16;
    localparam int PLANE_W         = 63;
    localparam int LANES           = 2;
    localparam int PAIRS           = 8;
    localparam int CODE_W          = 64;
    localparam int HDR_W           = 18;
    localparam int OUT_W           = 152;
    localparam int SIZE_W          = 8;

    // --------------------
    // vectors
    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [BEAT_W-1:0]              beat_t;
    typedef logic [PLANE_W-1:0]             plane_t;
    typedef logic [CODE_W-1:0]              codeword_t;
    typedef logic [$clog2(CODE_W+1)-1:0]    code_len_t;
    typedef logic [OUT_W-1:0]               out_bits_t;
    typedef logic [SIZE_W-1:0]              out_size_t;
    typedef logic [$clog2(PAIRS)-1:0]       pair_idx_t;
    typedef logic [$clog2(PLANES+1)-1:0]    run_len_t;

    // --------------------
    // buses
    typedef struct packed {
        beat_t data;
        logic  sop;
        logic  eop;
    } in_beat_t;

    typedef struct packed {
        plane_t dbx;
        logic   dbp_zero;
    } plane_in_t;

    typedef struct packed {
        codeword_t code;
        code_len_t len;
        logic      zero;
    } plane_code_t;

    // lane 0 carries the even plane of the pair
    typedef struct packed {
        plane_in_t [LANES-1:0] lane;
        word_t                 base;
        pair_idx_t             idx;
        logic                  valid;
    } pair_t;

    typedef struct packed {
        out_bits_t bits;
        out_size_t size;
        logic      sop;
        logic      eop;
    } out_beat_t;

    typedef enum logic {
        COLLECT,
        FULL
    } buf_state_e;

endpackage

/* rtl/bpc_plane_coder.sv */
/*
 * symbol coder for one DBX plane, combinational
 */
`timescale 1ns/1ns

module bpc_plane_coder (
    input  bpc_pkg::plane_in_t   plane_i,
    output bpc_pkg::plane_code_t code_o
);
    import bpc_pkg::*;

    plane_t                       dbx;
    logic [$clog2(PLANE_W)-1:0]   pos;
    logic                         one_hot;
    logic                         pair_hot;

    assign dbx = plane_i.dbx;

    // lowest set bit, last hit wins
    always_comb begin
        pos = '0;
        for (int i = PLANE_W - 1; i >= 0; i--) begin
            if (dbx[i]) begin
                pos = ($clog2(PLANE_W))'(i);
            end
        end
    end

    assign one_hot  = (dbx == (plane_t'(1) << pos));
    // a pair starting at the top bit would be cut off by the shift
    assign pair_hot = (pos != ($clog2(PLANE_W))'(PLANE_W - 1))
                      && (dbx == (plane_t'(3) << pos));

    always_comb begin
        code_o.zero = 1'b0;
        code_o.code = '0;
        code_o.len  = '0;
        if (dbx == '0) begin
            code_o.zero = 1'b1;
        end else if (&dbx) begin
            code_o.len = code_len_t'(5);
        end else if (plane_i.dbp_zero) begin
            code_o.code = {5'b00001, {(CODE_W-5){1'b0}}};
            code_o.len  = code_len_t'(5);
        end else if (pair_hot) begin
            code_o.code = {5'b00010, pos, {(CODE_W-11){1'b0}}};
            code_o.len  = code_len_t'(11);
        end else if (one_hot) begin
            code_o.code = {5'b00011, pos, {(CODE_W-11){1'b0}}};
            code_o.len  = code_len_t'(11);
        end else begin
            // raw plane behind a single 1
            code_o.code = {1'b1, dbx};
            code_o.len  = code_len_t'(CODE_W);
        end
    end

endmodule

/* rtl/bpc_block_buffer.sv */
/*
 * block buffer: beat capture with delta forming, transpose
 * into the encode-side planes, DBX plane pairs toward the coders
 */
`timescale 1ns/1ns

module bpc_block_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  bpc_pkg::in_beat_t in_i,
    output logic              ready_o,
    output bpc_pkg::pair_t    pair_o,
    input  logic              pair_take_i
);
    import bpc_pkg::*;

    // capture side
    buf_state_e                           state_q;
    logic [$clog2(BEATS_PER_BLOCK)-1:0]   beat_cnt_q;
    word_t                                base_q;
    word_t                                base_cur;
    word_t                                delta_q   [PLANE_W];
    word_t                                delta_cur [PLANE_W];
    word_t                                beat_delta [BEAT_W / WORD_W];
    plane_t                               plane_cur [PLANES];
    logic                                 accept;
    logic                                 xfer;

    // encode side
    plane_t                               planes_q [PLANES];
    word_t                                enc_base_q;
    pair_idx_t                            pair_cnt_q;
    logic                                 enc_valid_q;
    logic                                 last_take;
    logic                                 enc_free;

    assign ready_o   = (state_q == COLLECT);
    assign accept    = valid_i && ready_o;
    assign last_take = enc_valid_q && pair_take_i && (pair_cnt_q == pair_idx_t'(PAIRS - 1));
    assign enc_free  = !enc_valid_q || last_take;
    assign xfer      = (state_q == COLLECT) ? (accept && in_i.eop && enc_free) : enc_free;

    // --------------------
    // deltas of the incoming beat, merged over the stored ones
    assign base_cur = (accept && in_i.sop) ? in_i.data[BEAT_W-1 -: WORD_W] : base_q;

    always_comb begin
        for (int k = 0; k < BEAT_W / WORD_W; k++) begin
            beat_delta[k] = in_i.data[BEAT_W-1-k*WORD_W -: WORD_W] - base_cur;
        end
        for (int i = 0; i < PLANE_W; i++) begin
            // delta i belongs to word i+1
            if (accept && ((i + 1) / (BEAT_W / WORD_W) == int'(beat_cnt_q))) begin
                delta_cur[i] = beat_delta[(i + 1) % (BEAT_W / WORD_W)];
            end else begin
                delta_cur[i] = delta_q[i];
            end
        end
    end

    // plane 0 takes the msb, word 1 lands in bit 62
    always_comb begin
        for (int p = 0; p < PLANES; p++) begin
            for (int i = 0; i < PLANE_W; i++) begin
                plane_cur[p][PLANE_W-1-i] = delta_cur[i][WORD_W-1-p];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= COLLECT;
            beat_cnt_q <= '0;
        end else begin
            if (accept) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            case (state_q)
                COLLECT: if (accept && in_i.eop && !enc_free) state_q <= FULL;
                FULL:    if (enc_free) state_q <= COLLECT;
                default: state_q <= COLLECT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        base_q  <= base_cur;
        delta_q <= delta_cur;
        if (xfer) begin
            planes_q   <= plane_cur;
            enc_base_q <= base_cur;
        end
    end

    // --------------------
    // encode side pair counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enc_valid_q <= 1'b0;
            pair_cnt_q  <= '0;
        end else begin
            if (enc_valid_q && pair_take_i) begin
                pair_cnt_q <= pair_cnt_q + 1'b1;
                if (last_take) enc_valid_q <= 1'b0;
            end
            if (xfer) begin
                enc_valid_q <= 1'b1;
                pair_cnt_q  <= '0;
            end
        end
    end

    always_comb begin
        logic [$clog2(PLANES)-1:0] idx;
        plane_t                    prev;
        for (int l = 0; l < LANES; l++) begin
            idx  = ($clog2(PLANES))'(int'(pair_cnt_q) * LANES + l);
            prev = (idx == '0) ? '0 : planes_q[idx - 1'b1];
            pair_o.lane[l].dbx      = planes_q[idx] ^ prev;
            pair_o.lane[l].dbp_zero = ~|planes_q[idx];
        end
        pair_o.base  = enc_base_q;
        pair_o.idx   = pair_cnt_q;
        pair_o.valid = enc_valid_q;
    end

    // --------------------
    // source framing
    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (in_i.sop == (beat_cnt_q == '0)));

    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (in_i.eop == (beat_cnt_q == ($clog2(BEATS_PER_BLOCK))'(BEATS_PER_BLOCK - 1))));

endmodule

/* rtl/bpc_run_packer.sv */
/*
 * run packer: zero-run merging, base-word header,
 * sop/eop framing and the registered output beat
 */
`timescale 1ns/1ns

module bpc_run_packer (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  bpc_pkg::pair_t                             pair_i,
    input  bpc_pkg::plane_code_t [bpc_pkg::LANES-1:0]  code_i,
    output logic                                       pair_take_o,
    output logic                                       valid_o,
    output bpc_pkg::out_beat_t                         out_o,
    input  logic                                       ready_i
);
    import bpc_pkg::*;

    run_len_t   run_q;
    run_len_t   run_next;
    logic       first_q;
    logic       valid_q;
    out_beat_t  out_q;
    out_bits_t  acc_bits;
    out_size_t  acc_size;
    logic       any_code;
    logic       last_pair;
    logic       emit;

    function automatic codeword_t run_sym(input run_len_t n);
        run_len_t m;
        m = n - run_len_t'(2);
        if (n == run_len_t'(1)) begin
            return {3'b001, {(CODE_W-3){1'b0}}};
        end
        return {2'b01, m[3:0], {(CODE_W-6){1'b0}}};
    endfunction

    function automatic out_size_t run_sym_len(input run_len_t n);
        return (n == run_len_t'(1)) ? out_size_t'(3) : out_size_t'(6);
    endfunction

    // left-aligned symbol placed after the bits already packed
    function automatic out_bits_t place(input out_bits_t bits, input out_size_t at,
                                        input codeword_t sym);
        return bits | ({sym, {(OUT_W-CODE_W){1'b0}}} >> at);
    endfunction

    // --------------------
    // pack one pair
    assign last_pair = (pair_i.idx == pair_idx_t'(PAIRS - 1));

    always_comb begin
        acc_bits = first_q ? {2'b00, pair_i.base, {(OUT_W-HDR_W){1'b0}}} : '0;
        acc_size = first_q ? out_size_t'(HDR_W) : '0;
        run_next = run_q;
        any_code = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            if (code_i[l].zero) begin
                run_next = run_next + 1'b1;
            end else begin
                if (run_next != '0) begin
                    acc_bits = place(acc_bits, acc_size, run_sym(run_next));
                    acc_size = acc_size + run_sym_len(run_next);
                    run_next = '0;
                end
                acc_bits = place(acc_bits, acc_size, code_i[l].code);
                acc_size = acc_size + out_size_t'(code_i[l].len);
                any_code = 1'b1;
            end
        end
        // block end flushes what is left
        if (last_pair && run_next != '0) begin
            acc_bits = place(acc_bits, acc_size, run_sym(run_next));
            acc_size = acc_size + run_sym_len(run_next);
            run_next = '0;
        end
    end

    assign emit        = any_code || last_pair;
    assign pair_take_o = pair_i.valid && (!valid_q || ready_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            first_q <= 1'b1;
            run_q   <= '0;
        end else begin
            if (valid_q && ready_i) begin
                valid_q <= 1'b0;
            end
            if (pair_take_o) begin
                run_q <= run_next;
                if (emit) begin
                    valid_q <= 1'b1;
                    first_q <= last_pair;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_take_o && emit) begin
            out_q.bits <= acc_bits;
            out_q.size <= acc_size;
            out_q.sop  <= first_q;
            out_q.eop  <= last_pair;
        end
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

    // --------------------
    // output checks
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> (out_q.size <= out_size_t'(OUT_W)));

    assert property (@(posedge clk) disable iff (!rst_n)
        (valid_q && !ready_i) |=> (valid_q && $stable(out_q)));

endmodule

/* rtl/bpc_engine.sv */
/*
 * bit-plane compression engine top:
 * block buffer, one coder per lane, run packer
 */
`timescale 1ns/1ns

module bpc_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  bpc_pkg::in_beat_t   in_i,
    output logic                ready_o,
    output logic                valid_o,
    output bpc_pkg::out_beat_t  out_o,
    input  logic                ready_i
);
    import bpc_pkg::*;

    pair_t                    pair;
    logic                     pair_take;
    plane_code_t [LANES-1:0]  codes;

    bpc_block_buffer i_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .in_i        (in_i),
        .ready_o     (ready_o),
        .pair_o      (pair),
        .pair_take_i (pair_take)
    );

    // one coder per plane of the pair
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        bpc_plane_coder i_coder (
            .plane_i (pair.lane[l]),
            .code_o  (codes[l])
        );
    end

    bpc_run_packer i_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pair_i      (pair),
        .code_i      (codes),
        .pair_take_o (pair_take),
        .valid_o     (valid_o),
        .out_o       (out_o),
        .ready_i     (ready_i)
    );

endmodule

/* test/bpc_ref_model.svh */
/*
 * testbench reference model: LFSR step, DBX plane coding,
 * bit appending and packing of a block into expected beats
 */
`ifndef BPC_REF_MODEL_SVH
`define BPC_REF_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic plane_code_t code_plane(input plane_t dbx, input logic dbp_zero);
    plane_code_t c;
    int          ones;
    int          low;
    c    = '0;
    ones = $countones(dbx);
    low  = -1;
    for (int i = 0; i < PLANE_W; i++) begin
        if (dbx[i] && low < 0) begin
            low = i;
        end
    end
    if (ones == 0) begin
        c.zero = 1'b1;
    end else if (ones == PLANE_W) begin
        c.len = code_len_t'(5);
    end else if (dbp_zero) begin
        c.code[63:59] = 5'b00001;
        c.len         = code_len_t'(5);
    end else if (ones == 2 && low < PLANE_W - 1 && dbx[low + 1]) begin
        c.code[63:59] = 5'b00010;
        c.code[58:53] = 6'(low);
        c.len         = code_len_t'(11);
    end else if (ones == 1) begin
        c.code[63:59] = 5'b00011;
        c.code[58:53] = 6'(low);
        c.len         = code_len_t'(11);
    end else begin
        c.code = {1'b1, dbx};
        c.len  = code_len_t'(64);
    end
    return c;
endfunction

// msb of sym goes out first
function automatic void put_bits(inout out_bits_t bits, inout int pos,
                                 input codeword_t sym, input int len);
    for (int i = 0; i < len; i++) begin
        bits[OUT_W-1-pos-i] = sym[CODE_W-1-i];
    end
    pos = pos + len;
endfunction

function automatic void put_run(inout out_bits_t bits, inout int pos, input int n);
    logic [3:0] m;
    m = 4'(n - 2);
    if (n == 1) begin
        put_bits(bits, pos, {3'b001, 61'b0}, 3);
    end else begin
        put_bits(bits, pos, {2'b01, m, 58'b0}, 6);
    end
endfunction

// appends the expected beats of one block to exp_q
function automatic void model_block(input word_t w [64]);
    word_t       d [PLANE_W];
    plane_t      pl [PLANES];
    plane_t      dbx;
    plane_code_t c;
    out_beat_t   b;
    out_bits_t   bits;
    int          pos;
    int          run;
    int          p;
    logic        first;
    logic        any;
    for (int i = 1; i < 64; i++) begin
        d[i - 1] = w[i] - w[0];
    end
    for (int q = 0; q < PLANES; q++) begin
        for (int j = 0; j < PLANE_W; j++) begin
            pl[q][PLANE_W-1-j] = d[j][WORD_W-1-q];
        end
    end
    first = 1'b1;
    run   = 0;
    for (int k = 0; k < PAIRS; k++) begin
        bits = '0;
        pos  = 0;
        any  = 1'b0;
        if (first) begin
            put_bits(bits, pos, {2'b00, w[0], 46'b0}, HDR_W);
        end
        for (int l = 0; l < LANES; l++) begin
            p   = 2 * k + l;
            dbx = (p == 0) ? pl[0] : (pl[p] ^ pl[p - 1]);
            c   = code_plane(dbx, pl[p] == '0);
            if (c.zero) begin
                run = run + 1;
            end else begin
                if (run > 0) begin
                    put_run(bits, pos, run);
                    run = 0;
                end
                put_bits(bits, pos, c.code, int'(c.len));
                any = 1'b1;
            end
        end
        if (k == PAIRS - 1 && run > 0) begin
            put_run(bits, pos, run);
            run = 0;
        end
        if (any || k == PAIRS - 1) begin
            b.bits = bits;
            b.size = out_size_t'(pos);
            b.sop  = first;
            b.eop  = (k == PAIRS - 1);
            exp_q.push_back(b);
            first  = 1'b0;
        end
    end
endfunction

`endif

/* test/tb_bpc_engine.sv */
/*
 * testbench for the bit-plane compression engine: clock, reset,
 * block driver, randomly stalled sink with checks, test sequence
 */
`timescale 1ns/1ns

module tb_bpc_engine;
    import bpc_pkg::*;

    localparam int ACCEPT_LIMIT = 2000;
    localparam int DRAIN_LIMIT  = 5000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        valid_i;
    in_beat_t    in_i;
    logic        ready_o;
    logic        valid_o;
    out_beat_t   out_o;
    logic        ready_i;

    out_beat_t   exp_q [$];
    in_beat_t    in_q [$];
    word_t       cur_words [64];
    word_t       cur_delta [PLANE_W];
    out_beat_t   last_beat;
    string       test_name = "reset";
    logic [31:0] data_lfsr = 32'h9007;
    logic [31:0] stall_lfsr = 32'h9007;
    int          stall_mode = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          rx_count = 0;
    int          acc_beats = 0;
    int          blocks_in = 0;
    int          blocks_out = 0;
    logic        saw_backlog = 1'b0;
    logic        aborted = 1'b0;

`include "bpc_ref_model.svh"

    bpc_engine i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .in_i    (in_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .out_o   (out_o),
        .ready_i (ready_i)
    );

    always #50 clk = ~clk;

    // --------------------
    // random sources
    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < WORD_W; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w = {w[WORD_W-2:0], data_lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic sink_ready();
        logic a;
        logic b;
        if (stall_mode == 0) begin
            return 1'b1;
        end
        stall_lfsr = lfsr_step(stall_lfsr);
        a = stall_lfsr[0];
        if (stall_mode == 1) begin
            return a;
        end
        stall_lfsr = lfsr_step(stall_lfsr);
        b = stall_lfsr[0];
        return a & b;
    endfunction

    // --------------------
    // compare tasks
    task automatic check_beat(input string name, input out_beat_t exp, input out_beat_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input out_size_t exp, input out_size_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %s size: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // --------------------
    // block building and driving
    task automatic fill_random();
        for (int i = 0; i < 64; i++) begin
            cur_words[i] = rand_word();
        end
    endtask

    task automatic fill_from_delta(input word_t base);
        cur_words[0] = base;
        for (int i = 1; i < 64; i++) begin
            cur_words[i] = base + cur_delta[i - 1];
        end
    endtask

    task automatic queue_block();
        in_beat_t b;
        model_block(cur_words);
        for (int k = 0; k < BEATS_PER_BLOCK; k++) begin
            b.data = {cur_words[4*k], cur_words[4*k+1], cur_words[4*k+2], cur_words[4*k+3]};
            b.sop  = (k == 0);
            b.eop  = (k == BEATS_PER_BLOCK - 1);
            in_q.push_back(b);
        end
    endtask

    // valid stays high while beats are left
    task automatic drive_input();
        in_beat_t b;
        int       n;
        while (in_q.size() > 0 && !aborted) begin
            b = in_q.pop_front();
            valid_i <= 1'b1;
            in_i    <= b;
            n = 0;
            @(posedge clk);
            while (!ready_o && n < ACCEPT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!ready_o) begin
                other_errors++;
                aborted = 1'b1;
                $display("ERROR: %s: input beat not accepted in %0d cycles", test_name, n);
            end
        end
        valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < DRAIN_LIMIT && !aborted) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0 && !aborted) begin
            other_errors++;
            aborted = 1'b1;
            $display("ERROR: %s: %0d output beats never arrived", test_name, exp_q.size());
        end
        // room for a stray extra beat to show up
        repeat (4) @(posedge clk);
    endtask

    task automatic one_block();
        if (!aborted) begin
            queue_block();
            drive_input();
            wait_drain();
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // --------------------
    // sink, output checks and input bookkeeping
    initial begin
        out_beat_t exp_b;
        ready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                // capture may only stall with a whole block parked behind the encoder
                if (!ready_o) begin
                    saw_backlog = 1'b1;
                    if (acc_beats % BEATS_PER_BLOCK != 0 || blocks_in - blocks_out < 2) begin
                        other_errors++;
                        $display("ERROR: %s: ready_o low with no complete block waiting",
                                 test_name);
                    end
                end
                if (valid_i && ready_o) begin
                    acc_beats++;
                    if (in_i.eop) blocks_in++;
                end
                if (valid_o && ready_i) begin
                    if (exp_q.size() == 0) begin
                        other_errors++;
                        $display("ERROR: %s: output beat arrived with none expected", test_name);
                    end else begin
                        exp_b = exp_q.pop_front();
                        check_beat(test_name, exp_b, out_o);
                        check_size(test_name, exp_b.size, out_o.size);
                    end
                    last_beat = out_o;
                    rx_count++;
                    if (out_o.eop) blocks_out++;
                end
                ready_i <= sink_ready();
            end
        end
    end

    // --------------------
    // test sequence
    initial begin
        word_t     base;
        int        rx_before;
        out_beat_t lit;
        rst_n   = 1'b0;
        valid_i = 1'b0;
        in_i    = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("reset ready_o", 1'b1, ready_o);
        check_bit("reset valid_o", 1'b0, valid_o);

        test_name = "random_ready";
        for (int n = 0; n < 6; n++) begin
            fill_random();
            one_block();
        end

        test_name = "code_classes";
        // ramp: all-ones planes, a zero run, dbp-zero at the end
        for (int i = 1; i < 64; i++) cur_delta[i - 1] = 16'h8000 | (word_t'(i) << 1);
        fill_from_delta(rand_word());
        one_block();
        // single bits and adjacent pairs, top and bottom of the plane
        for (int i = 0; i < PLANE_W; i++) cur_delta[i] = '0;
        cur_delta[0]  = 16'h2002;
        cur_delta[4]  = 16'h0100;
        cur_delta[9]  = 16'h0008;
        cur_delta[10] = 16'h0008;
        cur_delta[61] = 16'h0400;
        cur_delta[62] = 16'h0400;
        fill_from_delta(rand_word());
        one_block();
        // random planes with a run of one and a run across pairs 1 and 2
        for (int i = 0; i < PLANE_W; i++) begin
            base = rand_word();
            base[12] = base[13];
            base[11] = base[13];
            base[9]  = base[10];
            cur_delta[i] = base;
        end
        fill_from_delta(rand_word());
        one_block();
        // constant delta
        for (int i = 0; i < PLANE_W; i++) cur_delta[i] = 16'hFFFF;
        fill_from_delta(rand_word());
        one_block();

        test_name = "whole_base";
        base = rand_word();
        for (int i = 0; i < 64; i++) cur_words[i] = base;
        rx_before = rx_count;
        one_block();
        if (!aborted && rx_count - rx_before != 1) begin
            other_errors++;
            $display("ERROR: whole_base: expected one beat, got %0d", rx_count - rx_before);
        end
        lit.bits = {2'b00, base, 6'b011110, 128'b0};
        lit.size = out_size_t'(24);
        lit.sop  = 1'b1;
        lit.eop  = 1'b1;
        check_beat("whole_base literal", lit, last_beat);
        check_size("whole_base literal", out_size_t'(24), last_beat.size);

        test_name  = "back_pressure";
        stall_mode = 1;
        for (int n = 0; n < 6; n++) begin
            fill_random();
            queue_block();
        end
        drive_input();
        wait_drain();

        test_name   = "back_to_back";
        stall_mode  = 2;
        saw_backlog = 1'b0;
        for (int n = 0; n < 8; n++) begin
            fill_random();
            if (n == 3) begin
                for (int i = 1; i < 64; i++) cur_words[i] = cur_words[0];
            end
            queue_block();
        end
        drive_input();
        wait_drain();
        check_bit("back_to_back capture stall seen", 1'b1, saw_backlog);

        finish_run();
    end

endmodule

/* project.f */
+incdir+test
rtl/bpc_pkg.sv
rtl/bpc_plane_coder.sv
rtl/bpc_block_buffer.sv
rtl/bpc_run_packer.sv
rtl/bpc_engine.sv
test/tb_bpc_engine.sv

/* run.sh */
#!/bin/sh
# build the engine testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_bpc_engine \
    -f project.f --Mdir obj_dir -o tb_bpc_engine

# a failed assertion stops the run early, the log search still decides
./obj_dir/tb_bpc_engine > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
